//--- hdl/riscv_fd_pkg.sv
package riscv_fd_pkg;

  localparam int XLEN = 64;                     // integer register and address width.
  localparam int ILEN = 32;                     // width of an expanded instruction.

  typedef logic [XLEN-1:0] xlen_t;              // pc and bus address.
  typedef logic [ILEN-1:0] inst_t;              // full 32-bit instruction word.
  typedef logic [15:0]     cinst_t;             // compressed instruction halfword.

  localparam xlen_t RESET_PC = 64'h0;           // first fetch address after reset.

  // RV base opcodes that the RVC expander can produce.
  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam logic [6:0] LUI    = 7'b0110111;
  localparam logic [6:0] JAL    = 7'b1101111;
  localparam logic [6:0] LOAD   = 7'b0000011;
  localparam logic [6:0] STORE  = 7'b0100011;
  localparam logic [6:0] OP     = 7'b0110011;
  localparam logic [6:0] BRANCH = 7'b1100011;

  // Quadrant codes held in the low two bits of a compressed instruction.
  localparam logic [1:0] C_Q0 = 2'b00;
  localparam logic [1:0] C_Q1 = 2'b01;
  localparam logic [1:0] C_Q2 = 2'b10;

endpackage

//--- hdl/riscv_fd_pcgen.sv
`timescale 1ns/100ps

module riscv_fd_pcgen (
  input  logic                 i_riscv_fd_clk,
  input  logic                 i_riscv_fd_rst,
  input  logic                 i_riscv_fd_take,
  input  logic                 i_riscv_fd_is_c,
  input  logic                 i_riscv_fd_redirect,
  input  riscv_fd_pkg::xlen_t  i_riscv_fd_redirect_pc,
  output riscv_fd_pkg::xlen_t  o_riscv_fd_pc_f,
  output riscv_fd_pkg::xlen_t  o_riscv_fd_pcnext_f
);

  // the sequential successor depends on the length of the instruction at pc.
  always_comb
  begin
    if (i_riscv_fd_is_c)
    begin
      o_riscv_fd_pcnext_f = o_riscv_fd_pc_f + 64'd2;   // compressed, one halfword.
    end
    else
    begin
      o_riscv_fd_pcnext_f = o_riscv_fd_pc_f + 64'd4;   // full word.
    end
  end

  // A redirect from a later stage wins over the sequential advance.
  always_ff @(posedge i_riscv_fd_clk or posedge i_riscv_fd_rst)
  begin
    if (i_riscv_fd_rst)
    begin
      o_riscv_fd_pc_f <= riscv_fd_pkg::RESET_PC;
    end
    else if (i_riscv_fd_redirect)
    begin
      o_riscv_fd_pc_f <= i_riscv_fd_redirect_pc;       // branch or trap target.
    end
    else if (i_riscv_fd_take)
    begin
      o_riscv_fd_pc_f <= o_riscv_fd_pcnext_f;          // item accepted by decode.
    end
  end

endmodule

//--- hdl/riscv_fd_wb_fetch.sv
`timescale 1ns/100ps

module riscv_fd_wb_fetch (
  input  logic                 i_riscv_fd_clk,
  input  logic                 i_riscv_fd_rst,
  input  riscv_fd_pkg::xlen_t  i_riscv_fd_pc_f,
  input  logic                 i_riscv_fd_take,
  input  logic                 i_riscv_fd_redirect,
  input  riscv_fd_pkg::inst_t  i_riscv_fd_wb_dat,
  input  logic                 i_riscv_fd_wb_ack,
  output logic                 o_riscv_fd_wb_cyc,
  output logic                 o_riscv_fd_wb_stb,
  output logic                 o_riscv_fd_wb_we,
  output riscv_fd_pkg::xlen_t  o_riscv_fd_wb_adr,
  output logic                 o_riscv_fd_valid_f,
  output riscv_fd_pkg::inst_t  o_riscv_fd_raw_f,
  output logic                 o_riscv_fd_is_c_f
);

  typedef enum logic [1:0] {ST_IDLE, ST_RD_LO, ST_RD_HI, ST_HOLD} state_t;

  state_t              state;
  logic                stale;          // read in flight belongs to a dropped pc.
  logic                buf_valid;
  riscv_fd_pkg::xlen_t buf_tag;        // word address of the buffered halfword.
  logic [15:0]         buf_hi;         // upper halfword of the last word read.
  riscv_fd_pkg::xlen_t word_adr;
  logic                buf_hit;
  logic                dat_is_c;
  logic                reading;

  assign word_adr = {i_riscv_fd_pc_f[63:2], 2'b00};
  assign buf_hit  = buf_valid && (buf_tag == word_adr);
  assign dat_is_c = (i_riscv_fd_wb_dat[1:0] != 2'b11);  // low half of an aligned word.
  assign reading  = (state == ST_RD_LO) || (state == ST_RD_HI);

  assign o_riscv_fd_wb_cyc  = reading;
  assign o_riscv_fd_wb_stb  = reading;     // single classic cycles, stb follows cyc.
  assign o_riscv_fd_wb_we   = 1'b0;        // read only master.
  assign o_riscv_fd_valid_f = (state == ST_HOLD);

  always_ff @(posedge i_riscv_fd_clk or posedge i_riscv_fd_rst)
  begin
    if (i_riscv_fd_rst)
    begin
      state             <= ST_IDLE;
      stale             <= 1'b0;
      buf_valid         <= 1'b0;
      buf_tag           <= '0;
      buf_hi            <= '0;
      o_riscv_fd_wb_adr <= '0;
      o_riscv_fd_raw_f  <= '0;
      o_riscv_fd_is_c_f <= 1'b0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (!i_riscv_fd_redirect)              // the new pc is not visible yet.
          begin
            if (i_riscv_fd_pc_f[1] && buf_hit)
            begin
              if (buf_hi[1:0] != 2'b11)
              begin
                o_riscv_fd_raw_f  <= {16'b0, buf_hi};   // served without a bus read.
                o_riscv_fd_is_c_f <= 1'b1;
                state             <= ST_HOLD;
              end
              else
              begin
                o_riscv_fd_wb_adr <= word_adr + 64'd4;  // upper half of a straddler.
                state             <= ST_RD_HI;
              end
            end
            else
            begin
              o_riscv_fd_wb_adr <= word_adr;
              state             <= ST_RD_LO;
            end
          end
        end
        ST_RD_LO:
        begin
          if (i_riscv_fd_wb_ack)
          begin
            if (stale || i_riscv_fd_redirect)
            begin
              state <= ST_IDLE;                  // data of a dropped pc.
            end
            else
            begin
              buf_tag   <= o_riscv_fd_wb_adr;
              buf_hi    <= i_riscv_fd_wb_dat[31:16];
              buf_valid <= 1'b1;
              if (i_riscv_fd_pc_f[1])
              begin
                state <= ST_IDLE;                // idle then serves it from the buffer.
              end
              else
              begin
                o_riscv_fd_raw_f  <= dat_is_c ? {16'b0, i_riscv_fd_wb_dat[15:0]}
                                              : i_riscv_fd_wb_dat;
                o_riscv_fd_is_c_f <= dat_is_c;
                state             <= ST_HOLD;
              end
            end
          end
        end
        ST_RD_HI:
        begin
          if (i_riscv_fd_wb_ack)
          begin
            if (stale || i_riscv_fd_redirect)
            begin
              state <= ST_IDLE;
            end
            else
            begin
              o_riscv_fd_raw_f  <= {i_riscv_fd_wb_dat[15:0], buf_hi};
              o_riscv_fd_is_c_f <= 1'b0;
              buf_tag           <= o_riscv_fd_wb_adr;
              buf_hi            <= i_riscv_fd_wb_dat[31:16];
              buf_valid         <= 1'b1;
              state             <= ST_HOLD;
            end
          end
        end
        default:
        begin
          if (i_riscv_fd_take || i_riscv_fd_redirect)
          begin
            state <= ST_IDLE;
          end
        end
      endcase

      if (i_riscv_fd_wb_ack)
      begin
        stale <= 1'b0;
      end
      else if (reading && i_riscv_fd_redirect)
      begin
        stale <= 1'b1;                           // let the bus cycle finish first.
      end

      if (i_riscv_fd_redirect)
      begin
        buf_valid <= 1'b0;
      end
    end
  end

endmodule

//--- hdl/riscv_fd_cdecomp.sv
`timescale 1ns/100ps

module riscv_fd_cdecomp (
  input  riscv_fd_pkg::inst_t i_riscv_fd_raw_f,
  input  logic                i_riscv_fd_is_c_f,
  output riscv_fd_pkg::inst_t o_riscv_fd_inst_f
);

  riscv_fd_pkg::cinst_t c;
  logic [4:0]           rdp;           // rd' or rs2' from bits 4:2.
  logic [4:0]           rs1p;          // rs1' from bits 9:7.
  logic [9:0]           uimm_spn;
  logic [6:0]           uimm_w;
  logic [7:0]           uimm_d;
  logic [11:0]          imm6_sx;       // sign extended 6-bit immediate.
  logic [11:0]          j_off;
  logic [8:0]           b_off;
  logic [2:0]           b_f3;

  assign c        = i_riscv_fd_raw_f[15:0];
  assign rdp      = {2'b01, c[4:2]};
  assign rs1p     = {2'b01, c[9:7]};
  assign uimm_spn = {c[10:7], c[12:11], c[5], c[6], 2'b00};
  assign uimm_w   = {c[5], c[12:10], c[6], 2'b00};
  assign uimm_d   = {c[6:5], c[12:10], 3'b000};
  assign imm6_sx  = {{6{c[12]}}, c[12], c[6:2]};
  assign j_off    = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
  assign b_off    = {c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
  assign b_f3     = c[13] ? 3'b001 : 3'b000;   // bnez maps to bne, beqz to beq.

  always_comb
  begin
    o_riscv_fd_inst_f = '0;                      // unsupported codes stay illegal.
    if (!i_riscv_fd_is_c_f)
    begin
      o_riscv_fd_inst_f = i_riscv_fd_raw_f;
    end
    else
    begin
      case (c[1:0])
        riscv_fd_pkg::C_Q0:
        begin
          case (c[15:13])
            3'b000:                              // c.addi4spn.
            begin
              if (uimm_spn != 10'b0)
              begin
                o_riscv_fd_inst_f = {2'b00, uimm_spn, 5'd2, 3'b000, rdp,
                                     riscv_fd_pkg::OP_IMM};
              end
            end
            3'b010: o_riscv_fd_inst_f = {5'b0, uimm_w, rs1p, 3'b010, rdp,
                                         riscv_fd_pkg::LOAD};
            3'b011: o_riscv_fd_inst_f = {4'b0, uimm_d, rs1p, 3'b011, rdp,
                                         riscv_fd_pkg::LOAD};
            3'b110: o_riscv_fd_inst_f = {5'b0, uimm_w[6:5], rdp, rs1p, 3'b010,
                                         uimm_w[4:0], riscv_fd_pkg::STORE};
            3'b111: o_riscv_fd_inst_f = {4'b0, uimm_d[7:5], rdp, rs1p, 3'b011,
                                         uimm_d[4:0], riscv_fd_pkg::STORE};
            default: o_riscv_fd_inst_f = '0;
          endcase
        end
        riscv_fd_pkg::C_Q1:
        begin
          case (c[15:13])
            3'b000: o_riscv_fd_inst_f = {imm6_sx, c[11:7], 3'b000, c[11:7],
                                         riscv_fd_pkg::OP_IMM};
            3'b010: o_riscv_fd_inst_f = {imm6_sx, 5'd0, 3'b000, c[11:7],
                                         riscv_fd_pkg::OP_IMM};
            3'b011:                              // c.lui, rd of x2 is c.addi16sp.
            begin
              if ((c[11:7] != 5'd2) && ({c[12], c[6:2]} != 6'b0))
              begin
                o_riscv_fd_inst_f = {{14{c[12]}}, c[12], c[6:2], c[11:7],
                                     riscv_fd_pkg::LUI};
              end
            end
            3'b101: o_riscv_fd_inst_f = {c[12], j_off[10:1], c[12], {8{c[12]}}, 5'd0,
                                         riscv_fd_pkg::JAL};
            3'b110,
            3'b111: o_riscv_fd_inst_f = {c[12], {2{c[12]}}, b_off[8:5], 5'd0, rs1p, b_f3,
                                         b_off[4:1], c[12], riscv_fd_pkg::BRANCH};
            default: o_riscv_fd_inst_f = '0;
          endcase
        end
        riscv_fd_pkg::C_Q2:
        begin
          if ((c[15:13] == 3'b100) && (c[6:2] != 5'd0))
          begin
            if (c[12])                           // c.add.
            begin
              o_riscv_fd_inst_f = {7'b0, c[6:2], c[11:7], 3'b000, c[11:7],
                                   riscv_fd_pkg::OP};
            end
            else                                 // c.mv.
            begin
              o_riscv_fd_inst_f = {7'b0, c[6:2], 5'd0, 3'b000, c[11:7],
                                   riscv_fd_pkg::OP};
            end
          end
        end
        default: o_riscv_fd_inst_f = '0;
      endcase
    end
  end

endmodule

//--- hdl/riscv_fd_ppreg.sv
`timescale 1ns/100ps

module riscv_fd_ppreg (
  input  logic                 i_riscv_fd_clk,
  input  logic                 i_riscv_fd_rst,
  input  logic                 i_riscv_fd_flush,
  input  logic                 i_riscv_fd_en,
  input  logic                 i_riscv_fd_valid_f,
  input  riscv_fd_pkg::xlen_t  i_riscv_fd_pc_f,
  input  riscv_fd_pkg::inst_t  i_riscv_fd_inst_f,
  input  riscv_fd_pkg::xlen_t  i_riscv_fd_pcplus4_f,
  output logic                 o_riscv_fd_valid_d,
  output riscv_fd_pkg::xlen_t  o_riscv_fd_pc_d,
  output riscv_fd_pkg::inst_t  o_riscv_fd_inst_d,
  output riscv_fd_pkg::xlen_t  o_riscv_fd_pcplus4_d,
  output logic [4:0]           o_riscv_fd_rs1_d,
  output logic [11:0]          o_riscv_fd_constimm12_d
);

  always_ff @(posedge i_riscv_fd_clk or posedge i_riscv_fd_rst)
  begin
    if (i_riscv_fd_rst)
    begin
      o_riscv_fd_valid_d      <= 1'b0;
      o_riscv_fd_pc_d         <= '0;
      o_riscv_fd_inst_d       <= '0;
      o_riscv_fd_pcplus4_d    <= '0;
      o_riscv_fd_rs1_d        <= '0;
      o_riscv_fd_constimm12_d <= '0;
    end
    else if (i_riscv_fd_flush)
    begin
      o_riscv_fd_valid_d      <= 1'b0;         // a bubble with all fields cleared.
      o_riscv_fd_pc_d         <= '0;
      o_riscv_fd_inst_d       <= '0;
      o_riscv_fd_pcplus4_d    <= '0;
      o_riscv_fd_rs1_d        <= '0;
      o_riscv_fd_constimm12_d <= '0;
    end
    else if (i_riscv_fd_en)
    begin
      o_riscv_fd_valid_d      <= o_riscv_fd_valid_d;   // decode is stalled.
      o_riscv_fd_pc_d         <= o_riscv_fd_pc_d;
      o_riscv_fd_inst_d       <= o_riscv_fd_inst_d;
      o_riscv_fd_pcplus4_d    <= o_riscv_fd_pcplus4_d;
      o_riscv_fd_rs1_d        <= o_riscv_fd_rs1_d;
      o_riscv_fd_constimm12_d <= o_riscv_fd_constimm12_d;
    end
    else
    begin
      o_riscv_fd_valid_d      <= i_riscv_fd_valid_f;   // low when fetch has nothing.
      o_riscv_fd_pc_d         <= i_riscv_fd_pc_f;
      o_riscv_fd_inst_d       <= i_riscv_fd_inst_f;
      o_riscv_fd_pcplus4_d    <= i_riscv_fd_pcplus4_f;
      o_riscv_fd_rs1_d        <= i_riscv_fd_inst_f[19:15];  // early for the register file.
      o_riscv_fd_constimm12_d <= i_riscv_fd_inst_f[31:20];
    end
  end

endmodule

//--- hdl/riscv_fd_fetch_top.sv
`timescale 1ns/100ps

module riscv_fd_fetch_top (
  input  logic                 i_riscv_fd_clk,
  input  logic                 i_riscv_fd_rst,
  input  logic                 i_riscv_fd_flush,
  input  logic                 i_riscv_fd_en,
  input  logic                 i_riscv_fd_redirect,
  input  riscv_fd_pkg::xlen_t  i_riscv_fd_redirect_pc,
  output logic                 o_riscv_fd_wb_cyc,
  output logic                 o_riscv_fd_wb_stb,
  output logic                 o_riscv_fd_wb_we,
  output riscv_fd_pkg::xlen_t  o_riscv_fd_wb_adr,
  input  riscv_fd_pkg::inst_t  i_riscv_fd_wb_dat,
  input  logic                 i_riscv_fd_wb_ack,
  output logic                 o_riscv_fd_valid_d,
  output riscv_fd_pkg::xlen_t  o_riscv_fd_pc_d,
  output riscv_fd_pkg::inst_t  o_riscv_fd_inst_d,
  output riscv_fd_pkg::xlen_t  o_riscv_fd_pcplus4_d,
  output logic [4:0]           o_riscv_fd_rs1_d,
  output logic [11:0]          o_riscv_fd_constimm12_d
);

  riscv_fd_pkg::xlen_t pc_f;
  riscv_fd_pkg::xlen_t pcnext_f;
  riscv_fd_pkg::inst_t raw_f;
  riscv_fd_pkg::inst_t inst_f;
  logic                valid_f;
  logic                is_c_f;
  logic                take;

  assign take = valid_f && !i_riscv_fd_en;   // the item moves into the pipeline register.

  riscv_fd_pcgen u_pcgen (
    .i_riscv_fd_clk         (i_riscv_fd_clk),
    .i_riscv_fd_rst         (i_riscv_fd_rst),
    .i_riscv_fd_take        (take),
    .i_riscv_fd_is_c        (is_c_f),
    .i_riscv_fd_redirect    (i_riscv_fd_redirect),
    .i_riscv_fd_redirect_pc (i_riscv_fd_redirect_pc),
    .o_riscv_fd_pc_f        (pc_f),
    .o_riscv_fd_pcnext_f    (pcnext_f)
  );

  riscv_fd_wb_fetch u_wb_fetch (
    .i_riscv_fd_clk      (i_riscv_fd_clk),
    .i_riscv_fd_rst      (i_riscv_fd_rst),
    .i_riscv_fd_pc_f     (pc_f),
    .i_riscv_fd_take     (take),
    .i_riscv_fd_redirect (i_riscv_fd_redirect),
    .i_riscv_fd_wb_dat   (i_riscv_fd_wb_dat),
    .i_riscv_fd_wb_ack   (i_riscv_fd_wb_ack),
    .o_riscv_fd_wb_cyc   (o_riscv_fd_wb_cyc),
    .o_riscv_fd_wb_stb   (o_riscv_fd_wb_stb),
    .o_riscv_fd_wb_we    (o_riscv_fd_wb_we),
    .o_riscv_fd_wb_adr   (o_riscv_fd_wb_adr),
    .o_riscv_fd_valid_f  (valid_f),
    .o_riscv_fd_raw_f    (raw_f),
    .o_riscv_fd_is_c_f   (is_c_f)
  );

  riscv_fd_cdecomp u_cdecomp (
    .i_riscv_fd_raw_f  (raw_f),
    .i_riscv_fd_is_c_f (is_c_f),
    .o_riscv_fd_inst_f (inst_f)
  );

  riscv_fd_ppreg u_ppreg (
    .i_riscv_fd_clk          (i_riscv_fd_clk),
    .i_riscv_fd_rst          (i_riscv_fd_rst),
    .i_riscv_fd_flush        (i_riscv_fd_flush),
    .i_riscv_fd_en           (i_riscv_fd_en),
    .i_riscv_fd_valid_f      (valid_f),
    .i_riscv_fd_pc_f         (pc_f),
    .i_riscv_fd_inst_f       (inst_f),
    .i_riscv_fd_pcplus4_f    (pcnext_f),
    .o_riscv_fd_valid_d      (o_riscv_fd_valid_d),
    .o_riscv_fd_pc_d         (o_riscv_fd_pc_d),
    .o_riscv_fd_inst_d       (o_riscv_fd_inst_d),
    .o_riscv_fd_pcplus4_d    (o_riscv_fd_pcplus4_d),
    .o_riscv_fd_rs1_d        (o_riscv_fd_rs1_d),
    .o_riscv_fd_constimm12_d (o_riscv_fd_constimm12_d)
  );

endmodule

//--- verification/riscv_fd_assertions.sv
`timescale 1ns/100ps

module riscv_fd_assertions (
  input logic                i_clk,
  input logic                i_rst,
  input logic                i_flush,
  input logic                i_en,
  input logic                i_cyc,
  input logic                i_stb,
  input logic                i_ack,
  input riscv_fd_pkg::xlen_t i_adr,
  input logic                i_valid_d,
  input riscv_fd_pkg::xlen_t i_pc_d,
  input riscv_fd_pkg::inst_t i_inst_d,
  input riscv_fd_pkg::xlen_t i_pcplus4_d,
  input logic [4:0]          i_rs1_d,
  input logic [11:0]         i_imm12_d
);

  a_single: assert property (@(posedge i_clk) disable iff (i_rst)
                             (i_stb && i_ack) |=> !(i_stb || i_cyc))
    else $error("bus cycle continued after ack");

  a_adr_hold: assert property (@(posedge i_clk) disable iff (i_rst)
                               (i_stb && !i_ack) |=> (i_stb && $stable(i_adr)))
    else $error("wishbone request changed before ack");

  a_flush: assert property (@(posedge i_clk) disable iff (i_rst) i_flush |=> !i_valid_d)
    else $error("valid_d set after a flush");

  a_stall: assert property (@(posedge i_clk) disable iff (i_rst) (i_en && !i_flush) |=>
                            ($stable(i_valid_d) && $stable(i_pc_d) && $stable(i_inst_d) &&
                             $stable(i_pcplus4_d) && $stable(i_rs1_d) &&
                             $stable(i_imm12_d)))
    else $error("decode outputs moved during a stall");

endmodule

bind riscv_fd_fetch_top riscv_fd_assertions u_assertions (
  .i_clk       (i_riscv_fd_clk),
  .i_rst       (i_riscv_fd_rst),
  .i_flush     (i_riscv_fd_flush),
  .i_en        (i_riscv_fd_en),
  .i_cyc       (o_riscv_fd_wb_cyc),
  .i_stb       (o_riscv_fd_wb_stb),
  .i_ack       (i_riscv_fd_wb_ack),
  .i_adr       (o_riscv_fd_wb_adr),
  .i_valid_d   (o_riscv_fd_valid_d),
  .i_pc_d      (o_riscv_fd_pc_d),
  .i_inst_d    (o_riscv_fd_inst_d),
  .i_pcplus4_d (o_riscv_fd_pcplus4_d),
  .i_rs1_d     (o_riscv_fd_rs1_d),
  .i_imm12_d   (o_riscv_fd_constimm12_d)
);

//--- verification/riscv_fd_tb.sv
`timescale 1ns/100ps

module riscv_fd_tb;

  logic                clk;
  logic                rst;
  logic                flush;
  logic                en;
  logic                redirect;
  riscv_fd_pkg::xlen_t redirect_pc;
  logic                wb_cyc;
  logic                wb_stb;
  logic                wb_we;
  riscv_fd_pkg::xlen_t wb_adr;
  riscv_fd_pkg::inst_t wb_dat;
  logic                wb_ack;
  logic                valid_d;
  riscv_fd_pkg::xlen_t pc_d;
  riscv_fd_pkg::inst_t inst_d;
  riscv_fd_pkg::xlen_t pcplus4_d;
  logic [4:0]          rs1_d;
  logic [11:0]         imm12_d;

  logic [15:0]         mem [0:255];    // halfword image of instruction memory.
  integer              seed = 9;
  int                  wait_cnt;
  int                  value_errors;
  int                  timeout_errors;
  int                  checked;
  riscv_fd_pkg::xlen_t exp_pc;

  riscv_fd_fetch_top DUT (
    .i_riscv_fd_clk          (clk),
    .i_riscv_fd_rst          (rst),
    .i_riscv_fd_flush        (flush),
    .i_riscv_fd_en           (en),
    .i_riscv_fd_redirect     (redirect),
    .i_riscv_fd_redirect_pc  (redirect_pc),
    .o_riscv_fd_wb_cyc       (wb_cyc),
    .o_riscv_fd_wb_stb       (wb_stb),
    .o_riscv_fd_wb_we        (wb_we),
    .o_riscv_fd_wb_adr       (wb_adr),
    .i_riscv_fd_wb_dat       (wb_dat),
    .i_riscv_fd_wb_ack       (wb_ack),
    .o_riscv_fd_valid_d      (valid_d),
    .o_riscv_fd_pc_d         (pc_d),
    .o_riscv_fd_inst_d       (inst_d),
    .o_riscv_fd_pcplus4_d    (pcplus4_d),
    .o_riscv_fd_rs1_d        (rs1_d),
    .o_riscv_fd_constimm12_d (imm12_d)
  );

  always #10 clk = ~clk;               // 20 ns period.

  function automatic riscv_fd_pkg::inst_t enc_i(logic [11:0] imm, logic [4:0] rs1,
                                                logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic riscv_fd_pkg::inst_t enc_s(logic [11:0] imm, logic [4:0] rs2,
                                                logic [4:0] rs1, logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], riscv_fd_pkg::STORE};
  endfunction

  // expands one halfword following the RVC tables and gives zero for unsupported codes.
  function automatic riscv_fd_pkg::inst_t expand(logic [15:0] c);
    logic [4:0]  rdp;
    logic [4:0]  rsp;
    logic [11:0] sx6;
    logic [11:0] uw;
    logic [11:0] ud;
    logic [11:0] spn;
    logic [12:0] bo;
    logic [20:0] jo;
    rdp = {2'b01, c[4:2]};
    rsp = {2'b01, c[9:7]};
    sx6 = {{6{c[12]}}, c[12], c[6:2]};
    uw  = {5'b0, c[5], c[12:10], c[6], 2'b00};
    ud  = {4'b0, c[6:5], c[12:10], 3'b000};
    spn = {2'b0, c[10:7], c[12:11], c[5], c[6], 2'b00};
    bo  = {{5{c[12]}}, c[6:5], c[2], c[11:10], c[4:3], 1'b0};
    jo  = {{10{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
    case ({c[15:13], c[1:0]})
      {3'b000, riscv_fd_pkg::C_Q0}:
        return (spn == 12'd0) ? 32'd0 : enc_i(spn, 5'd2, 3'b000, rdp, riscv_fd_pkg::OP_IMM);
      {3'b010, riscv_fd_pkg::C_Q0}: return enc_i(uw, rsp, 3'b010, rdp, riscv_fd_pkg::LOAD);
      {3'b011, riscv_fd_pkg::C_Q0}: return enc_i(ud, rsp, 3'b011, rdp, riscv_fd_pkg::LOAD);
      {3'b110, riscv_fd_pkg::C_Q0}: return enc_s(uw, rdp, rsp, 3'b010);
      {3'b111, riscv_fd_pkg::C_Q0}: return enc_s(ud, rdp, rsp, 3'b011);
      {3'b000, riscv_fd_pkg::C_Q1}: return enc_i(sx6, c[11:7], 3'b000, c[11:7],
                                                 riscv_fd_pkg::OP_IMM);
      {3'b010, riscv_fd_pkg::C_Q1}: return enc_i(sx6, 5'd0, 3'b000, c[11:7],
                                                 riscv_fd_pkg::OP_IMM);
      {3'b011, riscv_fd_pkg::C_Q1}:
        if (c[11:7] == 5'd2 || {c[12], c[6:2]} == 6'd0)
          return 32'd0;                          // c.addi16sp and reserved forms.
        else
          return {{14{c[12]}}, c[12], c[6:2], c[11:7], riscv_fd_pkg::LUI};
      {3'b101, riscv_fd_pkg::C_Q1}:
        return {jo[20], jo[10:1], jo[11], jo[19:12], 5'd0, riscv_fd_pkg::JAL};
      {3'b110, riscv_fd_pkg::C_Q1}, {3'b111, riscv_fd_pkg::C_Q1}:
        return {bo[12], bo[10:5], 5'd0, rsp, {2'b00, c[13]}, bo[4:1], bo[11],
                riscv_fd_pkg::BRANCH};
      {3'b100, riscv_fd_pkg::C_Q2}:
        if (c[6:2] == 5'd0)
          return 32'd0;                          // c.jr and c.jalr are not expanded.
        else
          return {7'b0, c[6:2], c[12] ? c[11:7] : 5'd0, 3'b000, c[11:7], riscv_fd_pkg::OP};
      default: return 32'd0;
    endcase
  endfunction

  function automatic riscv_fd_pkg::inst_t ref_fetch(riscv_fd_pkg::xlen_t pc,
                                                    output riscv_fd_pkg::xlen_t nxt);
    logic [7:0]  idx;
    logic [15:0] lo;
    logic [15:0] hi;
    idx = pc[8:1];
    lo  = mem[idx];
    hi  = mem[idx + 8'd1];
    if (lo[1:0] == 2'b11)
    begin
      nxt = pc + 64'd4;
      return {hi, lo};
    end
    nxt = pc + 64'd2;
    return expand(lo);
  endfunction

  task automatic check_inst(riscv_fd_pkg::inst_t act, riscv_fd_pkg::inst_t exp, string name);
    if (act !== exp)
    begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, act, exp);
      value_errors++;
    end
  endtask

  task automatic check_pc(riscv_fd_pkg::xlen_t act, riscv_fd_pkg::xlen_t exp, string name);
    if (act !== exp)
    begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, act, exp);
      value_errors++;
    end
  endtask

  task automatic check_field(logic [11:0] act, logic [11:0] exp, string name);
    if (act !== exp)
    begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, act, exp);
      value_errors++;
    end
  endtask

  // slave with 0 to 3 wait states that drives data and ack on the falling edge.
  always @(negedge clk)
  begin
    if (rst || wb_ack)
    begin
      wb_ack = 1'b0;
    end
    else if (wb_cyc && wb_stb)
    begin
      check_field({11'd0, wb_we}, 12'd0, "wb_we");   // the fetch master only reads.
      if (wait_cnt == 0)
      begin
        wb_dat   = {mem[wb_adr[8:1] + 8'd1], mem[wb_adr[8:1]]};
        wb_ack   = 1'b1;
        wait_cnt = {$random(seed)} % 4;
      end
      else
      begin
        wait_cnt--;
      end
    end
  end

  // compares every freshly loaded decode item against the reference stream.
  always
  begin
    logic                fl;
    logic                ld;
    riscv_fd_pkg::xlen_t tgt;
    riscv_fd_pkg::xlen_t nxt;
    riscv_fd_pkg::inst_t exp;
    @(posedge clk);
    fl  = flush;
    ld  = !en && !flush && !rst;
    tgt = redirect_pc;
    @(negedge clk);
    if (rst)
    begin
      exp_pc = riscv_fd_pkg::RESET_PC;
    end
    else if (fl)
    begin
      check_field({11'd0, valid_d}, 12'd0, "valid_d after flush");
      check_pc(pc_d, 64'd0, "pc_d after flush");
      check_inst(inst_d, 32'd0, "inst_d after flush");
      check_pc(pcplus4_d, 64'd0, "pcplus4_d after flush");
      check_field({7'd0, rs1_d}, 12'd0, "rs1_d after flush");
      check_field(imm12_d, 12'd0, "constimm12_d after flush");
      exp_pc = tgt;                              // stream resumes at the target.
    end
    else if (ld && valid_d)
    begin
      exp = ref_fetch(exp_pc, nxt);
      check_pc(pc_d, exp_pc, "pc_d");
      check_inst(inst_d, exp, "inst_d");
      check_pc(pcplus4_d, nxt, "pcplus4_d");
      check_field({7'd0, rs1_d}, {7'd0, exp[19:15]}, "rs1_d");
      check_field(imm12_d, exp[31:20], "constimm12_d");
      exp_pc = nxt;
      checked++;
    end
  end

  task automatic wait_cyc();
    int n;
    n = 0;
    while (!wb_cyc && n < 100)
    begin
      @(negedge clk);
      n++;
    end
    if (!wb_cyc)
    begin
      $display("Timeout: the DUT never started a bus cycle");
      timeout_errors++;
    end
  endtask

  task automatic wait_items(int count);
    int n;
    int goal;
    n    = 0;
    goal = checked + count;
    while (checked < goal && n < 400)
    begin
      @(negedge clk);
      n++;
    end
    if (checked < goal)
    begin
      $display("Timeout: decode received too few instructions");
      timeout_errors++;
    end
  endtask

  task automatic redirect_to(riscv_fd_pkg::xlen_t target);
    flush       = 1'b1;                          // a flush always comes with a redirect.
    redirect    = 1'b1;
    redirect_pc = target;
    @(negedge clk);
    flush       = 1'b0;
    redirect    = 1'b0;
  endtask

  initial
  begin
    riscv_fd_pkg::xlen_t held_pc;
    riscv_fd_pkg::inst_t held_inst;
    clk = 1'b0;
    rst = 1'b1;
    flush = 1'b0;
    en = 1'b0;
    redirect = 1'b0;
    redirect_pc = '0;
    wb_dat = '0;
    wb_ack = 1'b0;
    value_errors = 0;
    timeout_errors = 0;
    checked = 0;
    exp_pc = riscv_fd_pkg::RESET_PC;
    wait_cnt = {$random(seed)} % 4;
    for (int w = 0; w < 128; w++)
    begin
      {mem[2*w+1], mem[2*w]} = enc_i(12'(w * 37), 5'(w), 3'b000, 5'(w + 1),
                                     riscv_fd_pkg::OP_IMM);
    end
    {mem[1], mem[0]} = 32'h12300093;             // mixed program with straddlers.
    {mem[3], mem[2]} = 32'h002081b3;
    mem[4]  = 16'h10F5;
    {mem[6], mem[5]} = 32'h00412083;             // starts at pc 0x0a.
    mem[7]  = 16'h429D;
    mem[8]  = 16'h6305;
    {mem[10], mem[9]} = 32'hfff00513;
    mem[11] = 16'h0800;
    mem[12] = 16'h4504;
    mem[13] = 16'h6880;
    mem[14] = 16'hC044;
    mem[15] = 16'hE588;
    {mem[17], mem[16]} = 32'h00b50633;
    mem[18] = 16'h8636;
    mem[19] = 16'h9636;
    mem[20] = 16'hC499;
    mem[21] = 16'hF955;
    mem[22] = 16'hB669;
    mem[23] = 16'h8082;                          // c.jr is not expanded.
    mem[24] = 16'h0001;
    {mem[26], mem[25]} = 32'h02a00593;
    mem[27] = 16'h0000;
    {mem[29], mem[28]} = 32'h00000013;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    check_field({11'd0, valid_d}, 12'd0, "valid_d after reset");
    check_pc(pc_d, 64'd0, "pc_d after reset");
    check_inst(inst_d, 32'd0, "inst_d after reset");
    wait_cyc();
    check_pc(wb_adr, riscv_fd_pkg::RESET_PC, "first wb_adr");
    wait_items(12);
    en = 1'b1;                                   // stall decode for six cycles.
    @(negedge clk);
    held_pc   = pc_d;
    held_inst = inst_d;
    repeat (6) @(negedge clk);
    check_pc(pc_d, held_pc, "stalled pc_d");
    check_inst(inst_d, held_inst, "stalled inst_d");
    en = 1'b0;
    wait_items(6);
    wait_cyc();
    redirect_to(64'h0a);                         // drops the read in flight.
    wait_items(8);
    redirect_to(64'h24);
    wait_items(10);
    wait_cyc();
    redirect_to(64'h30);
    wait_items(20);
    $display("errors: %0d value mismatches, %0d timeouts, %0d instructions checked",
             value_errors, timeout_errors, checked);
    if (value_errors == 0 && timeout_errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- vlog.f
hdl/riscv_fd_pkg.sv
hdl/riscv_fd_pcgen.sv
hdl/riscv_fd_wb_fetch.sv
hdl/riscv_fd_cdecomp.sv
hdl/riscv_fd_ppreg.sv
hdl/riscv_fd_fetch_top.sv
verification/riscv_fd_assertions.sv
verification/riscv_fd_tb.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module riscv_fd_tb -o riscv_fd_sim

run: compile
	@out="$$(./obj_dir/riscv_fd_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir
